//--- logic/ps2_pkg.sv
// PS/2 frame layout shared by the receiver, the scan FIFO and the bus slave.
// Bit indices refer to the receiver shift register once a full frame is in.

`default_nettype none

package ps2_pkg;

   ////////////////////////////////////////////////////////////
   // Frame geometry.

   localparam int PS2_FRAME_BITS = 11;   // Start, 8 data, parity, stop.
   localparam int PS2_CODE_BITS  = 8;

   // Positions in the shift register, LSB first on the wire.
   localparam int PS2_START_IDX  = 0;
   localparam int PS2_CODE_LSB   = 1;
   localparam int PS2_CODE_MSB   = 8;
   localparam int PS2_PARITY_IDX = 9;    // Odd parity over the code.
   localparam int PS2_STOP_IDX   = 10;

   ////////////////////////////////////////////////////////////
   // One received frame as stored in the FIFO.

   typedef struct packed {
      logic                     frame_err;   // Short frame, stuck clock, bad start or stop.
      logic                     parity_err;  // Full frame with even parity.
      logic [PS2_CODE_BITS-1:0] code;        // Scan code byte.
   } ps2_frame_t;

endpackage

`default_nettype wire

//--- logic/wb_pkg.sv
// Wishbone classic request and response bundles plus the register map
// of the keyboard port. Addresses are word addresses.

`default_nettype none

package wb_pkg;

   localparam int WB_ADR_BITS = 4;
   localparam int WB_DAT_BITS = 16;

   // Master to slave.
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [WB_ADR_BITS-1:0] adr;
      logic [WB_DAT_BITS-1:0] dat_w;
   } wb_req_t;

   // Slave to master.
   typedef struct packed {
      logic                   ack;
      logic [WB_DAT_BITS-1:0] dat_r;
   } wb_rsp_t;

   ////////////////////////////////////////////////////////////
   // Register map.

   localparam logic [WB_ADR_BITS-1:0] ADDR_DATA   = 4'd0;  // Read pops a frame.
   localparam logic [WB_ADR_BITS-1:0] ADDR_STATUS = 4'd1;

   localparam int DATA_VALID_BIT      = 15;
   localparam int DATA_FRAME_ERR_BIT  = 9;
   localparam int DATA_PARITY_ERR_BIT = 8;   // Code sits in 7:0.
   localparam int STAT_OVERFLOW_BIT   = 8;   // Count sits in 4:0.
   localparam int STAT_BUSY_BIT       = 9;

endpackage

`default_nettype wire

//--- logic/ps2_rx.sv
// PS/2 device-to-host receiver. Shifts in one 11-bit frame per event and
// reports it, checked, once the PS/2 clock has been quiet for one period.
// CLK_KHZ / PS2_KHZ sets the quiet timeout in system clocks.

`default_nettype none

module ps2_rx #(
   parameter int CLK_KHZ = 50000,   // System clock rate.
   parameter int PS2_KHZ = 10       // Nominal PS/2 clock rate.
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                ps2_clk,      // Asynchronous.
   input  logic                ps2_data,     // Asynchronous.
   output logic                frame_valid,  // One-cycle strobe.
   output ps2_pkg::ps2_frame_t frame,
   output logic                busy
);

   import ps2_pkg::*;

   localparam int TIMEOUT    = CLK_KHZ / PS2_KHZ;        // Quiet period.
   localparam int TIMER_BITS = $clog2(TIMEOUT + 1);
   localparam int CNT_BITS   = $clog2(PS2_FRAME_BITS + 1);

   logic [1:0]                clk_sync;     // Two-flop synchronizers.
   logic [1:0]                data_sync;
   logic [3:0]                clk_hist;     // Oldest sample in bit 3.
   logic                      fall_edge;
   logic                      rise_edge;
   logic                      clk_level;
   logic [TIMER_BITS-1:0]     timer;        // Clocks since last edge.
   logic                      timeout;
   logic [CNT_BITS-1:0]       bit_cnt;
   logic [PS2_FRAME_BITS-1:0] shift;        // First bit ends up in bit 0.
   logic                      close;
   logic                      full_len;
   logic                      frame_err;
   logic                      parity_err;

   ////////////////////////////////////////////////////////////
   // Line synchronizers and edge detection.

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;    // Idle lines sit high.
         data_sync <= 2'b11;
         clk_hist  <= 4'b1111;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_hist  <= {clk_hist[2:0], clk_sync[1]};
      end
   end

   // Two samples each side, so a single-sample glitch is ignored.
   assign fall_edge = clk_hist == 4'b1100;
   assign rise_edge = clk_hist == 4'b0011;
   assign clk_level = clk_hist[0];

   ////////////////////////////////////////////////////////////
   // Quiet timer, bit counter and shift register.

   always_ff @(posedge clk) begin
      if (reset) begin
         timer <= '0;
      end else if (fall_edge || rise_edge) begin
         timer <= '0;
      end else if (!timeout) begin
         timer <= timer + 1'b1;   // Saturates at the timeout.
      end
   end

   assign timeout = timer == TIMER_BITS'(TIMEOUT);

   // Close only frames that saw at least one falling edge.
   assign close = timeout && (bit_cnt != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt <= '0;
      end else if (close) begin
         bit_cnt <= fall_edge ? CNT_BITS'(1) : '0;   // Edge may start the next frame.
      end else if (fall_edge && (bit_cnt != '1)) begin
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

   // Data is stable around the falling edge.
   always_ff @(posedge clk) begin
      if (fall_edge) begin
         shift <= {data_sync[1], shift[PS2_FRAME_BITS-1:1]};
      end
   end

   ////////////////////////////////////////////////////////////
   // Frame checks, valid only in the close cycle.

   // Full length with the clock released high.
   assign full_len = (bit_cnt == CNT_BITS'(PS2_FRAME_BITS)) && clk_level;

   assign frame_err = !full_len
                      || shift[PS2_START_IDX]      // Start must be low.
                      || !shift[PS2_STOP_IDX];     // Stop must be high.

   // Odd parity over code and parity bit.
   assign parity_err = full_len && !(^shift[PS2_PARITY_IDX:PS2_CODE_LSB]);

   always_ff @(posedge clk) begin
      if (reset) begin
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= close;   // One cycle after close.
      end
   end

   always_ff @(posedge clk) begin
      if (close) begin
         frame.code       <= shift[PS2_CODE_MSB:PS2_CODE_LSB];
         frame.parity_err <= parity_err;
         frame.frame_err  <= frame_err;
      end
   end

   assign busy = bit_cnt != '0;   // Mid-frame.

endmodule

`default_nettype wire

//--- logic/scan_fifo.sv
// Ring buffer of received PS/2 frames between the receiver and the bus.
// Pushes while full are dropped and latch a sticky overflow flag.

`default_nettype none

module scan_fifo #(
   parameter int FIFO_DEPTH = 4   // Power of two, 16 at most.
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                push,
   input  ps2_pkg::ps2_frame_t push_data,
   input  logic                pop,
   input  logic                clear_overflow,
   output ps2_pkg::ps2_frame_t head,        // Oldest entry.
   output logic [4:0]          count,
   output logic                overflow
);

   import ps2_pkg::*;

   localparam int PTR_BITS = $clog2(FIFO_DEPTH);

   ps2_frame_t          mem [FIFO_DEPTH];
   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic                full;
   logic                do_push;
   logic                do_pop;

   assign full    = count == 5'(FIFO_DEPTH);
   assign do_push = push && !full;
   assign do_pop  = pop && (count != '0);   // Empty pops ignored.

   // Storage.
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap on their own, depth is a power of two.
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {4'b0, do_push} - {4'b0, do_pop};
      end
   end

   // Sticky until cleared; a new drop wins over a clear.
   always_ff @(posedge clk) begin
      if (reset) begin
         overflow <= 1'b0;
      end else if (push && full) begin
         overflow <= 1'b1;
      end else if (clear_overflow) begin
         overflow <= 1'b0;
      end
   end

   assign head = mem[rd_ptr];

endmodule

`default_nettype wire

//--- logic/ps2_wb_regs.sv
// Wishbone classic slave of the keyboard port. DATA reads pop the scan
// FIFO, STATUS shows count, overflow and receiver busy.
// Write STATUS with the overflow bit set to clear overflow.

`default_nettype none

module ps2_wb_regs (
   input  logic                clk,
   input  logic                reset,
   input  wb_pkg::wb_req_t     wb_req,
   output wb_pkg::wb_rsp_t     wb_rsp,
   input  ps2_pkg::ps2_frame_t head,
   input  logic [4:0]          count,
   input  logic                overflow,
   input  logic                busy,
   output logic                pop,             // Pulse in the ack cycle.
   output logic                clear_overflow   // Pulse in the ack cycle.
);

   import wb_pkg::*;

   logic                   req_hit;     // New request this cycle.
   logic                   not_empty;
   logic                   ack;
   logic [WB_DAT_BITS-1:0] rd_data;
   logic [WB_DAT_BITS-1:0] data_word;
   logic [WB_DAT_BITS-1:0] status_word;
   logic [WB_DAT_BITS-1:0] read_word;

   assign req_hit   = wb_req.cyc && wb_req.stb && !ack;   // One ack per request.
   assign not_empty = count != '0;

   ////////////////////////////////////////////////////////////
   // Read words.

   always_comb begin
      data_word = '0;   // Empty FIFO reads as zero.
      if (not_empty) begin
         data_word[DATA_VALID_BIT]      = 1'b1;
         data_word[DATA_FRAME_ERR_BIT]  = head.frame_err;
         data_word[DATA_PARITY_ERR_BIT] = head.parity_err;
         data_word[7:0]                 = head.code;
      end
   end

   always_comb begin
      status_word                    = '0;
      status_word[4:0]               = count;
      status_word[STAT_OVERFLOW_BIT] = overflow;
      status_word[STAT_BUSY_BIT]     = busy;
   end

   always_comb begin
      case (wb_req.adr)
         ADDR_DATA:   read_word = data_word;
         ADDR_STATUS: read_word = status_word;
         default:     read_word = '0;        // Unmapped.
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Ack and side-effect pulses, all one cycle after the request.

   always_ff @(posedge clk) begin
      if (reset) begin
         ack            <= 1'b0;
         pop            <= 1'b0;
         clear_overflow <= 1'b0;
      end else begin
         ack            <= req_hit;
         pop            <= req_hit && !wb_req.we && (wb_req.adr == ADDR_DATA) && not_empty;
         clear_overflow <= req_hit && wb_req.we && (wb_req.adr == ADDR_STATUS)
                           && wb_req.dat_w[STAT_OVERFLOW_BIT];
      end
   end

   // Head captured before the pop moves it.
   always_ff @(posedge clk) begin
      if (req_hit) begin
         rd_data <= wb_req.we ? '0 : read_word;
      end
   end

   assign wb_rsp = '{ack: ack, dat_r: rd_data};

endmodule

`default_nettype wire

//--- logic/ps2_keyboard_port.sv
// PS/2 keyboard port top level. Receiver frames go into the scan FIFO,
// which a Wishbone master drains through the register slave.

`default_nettype none

module ps2_keyboard_port #(
   parameter int CLK_KHZ    = 50000,   // System clock rate.
   parameter int PS2_KHZ    = 10,      // PS/2 clock rate.
   parameter int FIFO_DEPTH = 4        // Power of two, 16 at most.
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            ps2_clk,    // Asynchronous.
   input  logic            ps2_data,   // Asynchronous.
   input  wb_pkg::wb_req_t wb_req,
   output wb_pkg::wb_rsp_t wb_rsp
);

   import ps2_pkg::*;

   logic       frame_valid;
   ps2_frame_t frame;
   logic       busy;
   ps2_frame_t head;
   logic [4:0] count;
   logic       overflow;
   logic       pop;
   logic       clear_overflow;

   ////////////////////////////////////////////////////////////
   // Receiver, FIFO and bus slave.

   ps2_rx #(
      .CLK_KHZ (CLK_KHZ),
      .PS2_KHZ (PS2_KHZ)
   ) ps2_rx_inst (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .frame_valid (frame_valid),
      .frame       (frame),
      .busy        (busy)
   );

   // No back-pressure, a full FIFO drops the frame.
   scan_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) scan_fifo_inst (
      .clk            (clk),
      .reset          (reset),
      .push           (frame_valid),
      .push_data      (frame),
      .pop            (pop),
      .clear_overflow (clear_overflow),
      .head           (head),
      .count          (count),
      .overflow       (overflow)
   );

   ps2_wb_regs ps2_wb_regs_inst (
      .clk            (clk),
      .reset          (reset),
      .wb_req         (wb_req),
      .wb_rsp         (wb_rsp),
      .head           (head),
      .count          (count),
      .overflow       (overflow),
      .busy           (busy),
      .pop            (pop),
      .clear_overflow (clear_overflow)
   );

endmodule

`default_nettype wire

//--- sim/ps2_keyboard_port_properties.sv
// Concurrent checks on the Wishbone handshake and the scan FIFO.
// Bound into the keyboard port top level.

`default_nettype none

module ps2_keyboard_port_properties #(
   parameter int FIFO_DEPTH = 4
) (
   input logic            clk,
   input logic            reset,
   input wb_pkg::wb_req_t wb_req,
   input wb_pkg::wb_rsp_t wb_rsp,
   input logic [4:0]      count,
   input logic            pop
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;   // Failed assertions so far.

   // Ack answers a request seen one cycle earlier.
   ack_after_req: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
      else begin
         fail_count++;
         $error("ack raised without cyc and stb in the previous cycle");
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         fail_count++;
         $error("ack held for two cycles");
      end

   count_in_range: assert property (@(posedge clk) disable iff (reset)
      count <= 5'(FIFO_DEPTH))
      else begin
         fail_count++;
         $error("FIFO count above depth");
      end

   // Slave must gate pops on a non-empty FIFO.
   no_empty_pop: assert property (@(posedge clk) disable iff (reset)
      pop |-> (count != '0))
      else begin
         fail_count++;
         $error("pop issued with an empty FIFO");
      end

endmodule

bind ps2_keyboard_port ps2_keyboard_port_properties #(
   .FIFO_DEPTH (FIFO_DEPTH)
) properties_inst (
   .clk    (clk),
   .reset  (reset),
   .wb_req (wb_req),
   .wb_rsp (wb_rsp),
   .count  (count),
   .pop    (pop)
);

`default_nettype wire

//--- sim/ps2_keyboard_port_tb.sv
// Testbench of the PS/2 keyboard port. A PS/2 device model sends frames,
// a Wishbone master drains them and a queue model predicts every read.
// Run it as the simulation top, the assertion module is bound in separately.

`default_nettype none

module ps2_keyboard_port_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import ps2_pkg::*;
   import wb_pkg::*;

   localparam int CLK_KHZ     = 1000;   // Quiet timeout of 100 clocks.
   localparam int PS2_KHZ     = 10;
   localparam int FIFO_DEPTH  = 4;
   localparam int HALF        = 20;     // PS/2 half period in clocks.
   localparam int FRAME_CYC   = PS2_FRAME_BITS * 2 * HALF + CLK_KHZ / PS2_KHZ + 300;
   localparam int NUM_FRAMES  = 20 + 3 + 1 + FIFO_DEPTH + 2;
   localparam int WATCHDOG_NS = (NUM_FRAMES * FRAME_CYC + 2000) * 8;

   logic        clk = 1'b0;
   logic        reset;
   logic        ps2_clk;
   logic        ps2_data;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;

   integer      seed = 32'h33d0_2828;
   int          checks = 0;
   int          errors = 0;
   int          errors_before = 0;
   logic [15:0] exp_q[$];    // Expected DATA words, oldest first.
   logic [15:0] mask_q[$];   // Bits compared per word.
   logic        model_ovf = 1'b0;

   ps2_keyboard_port #(
      .CLK_KHZ    (CLK_KHZ),
      .PS2_KHZ    (PS2_KHZ),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) ps2_keyboard_port_inst (
      .clk      (clk),
      .reset    (reset),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp)
   );

   initial begin
      forever #4 clk = ~clk;   // 8 ns period.
   end

   // Sized for every frame plus polling slack.
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Checking and bus master.

   task automatic check_word(input string name, input logic [15:0] got,
                             input logic [15:0] exp, input logic [15:0] mask);
      checks++;
      if ((got & mask) !== (exp & mask)) begin
         errors++;
         $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Classic cycle, request held until ack.
   task automatic bus_access(input logic we, input logic [3:0] adr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
      @(negedge clk);
      while (!wb_rsp.ack && waited < 16) begin
         waited++;
         @(negedge clk);
      end
      rdata = wb_rsp.dat_r;
      if (!wb_rsp.ack) begin
         errors++;
         $display("No ack from the slave within 16 cycles at %0d ns", $time);
      end
      wb_req = '0;
   endtask

   ////////////////////////////////////////////////////////////
   // Queue model of the FIFO and register rules.

   function automatic logic [15:0] model_status();
      return {7'b0, model_ovf, 3'b0, 5'(exp_q.size())};   // Busy expected low.
   endfunction

   function automatic logic [7:0] rand_byte();
      return 8'($random(seed));
   endfunction

   task automatic read_status();
      logic [15:0] got;
      bus_access(1'b0, ADDR_STATUS, 16'h0, got);
      check_word("wb_rsp.dat_r (STATUS)", got, model_status(), 16'hffff);
   endtask

   task automatic read_data();
      logic [15:0] got;
      logic [15:0] exp;
      logic [15:0] mask;
      exp  = 16'h0;       // Empty FIFO reads as zero.
      mask = 16'hffff;
      if (exp_q.size() != 0) begin
         exp  = exp_q.pop_front();
         mask = mask_q.pop_front();
      end
      bus_access(1'b0, ADDR_DATA, 16'h0, got);
      check_word("wb_rsp.dat_r (DATA)", got, exp, mask);
   endtask

   // Poll STATUS until the model state shows up, or give up.
   task automatic wait_frame();
      logic [15:0] status;
      int          polls;
      polls = 0;
      do begin
         bus_access(1'b0, ADDR_STATUS, 16'h0, status);
         polls++;
      end while (status != model_status() && polls < 400);
      if (status != model_status()) begin
         errors++;
         $display("Frame was not delivered to the FIFO in time at %0d ns", $time);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // PS/2 device model.

   // Data changes mid-way through the clock high phase.
   task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                             input logic bad_start, input logic bad_stop, input int n_bits);
      logic [10:0] bits;
      bits = {~bad_stop, ~(^code) ^ bad_parity, code, bad_start};   // Odd parity.
      @(negedge clk);
      for (int i = 0; i < n_bits; i++) begin
         ps2_data = bits[i];
         repeat (HALF / 2) @(negedge clk);
         ps2_clk = 1'b0;
         repeat (HALF) @(negedge clk);
         ps2_clk = 1'b1;
         repeat (HALF / 2) @(negedge clk);
      end
      ps2_data = 1'b1;   // Idle.
   endtask

   task automatic send_checked(input logic [7:0] code, input logic bad_parity,
                               input logic bad_start, input logic bad_stop, input int n_bits);
      ps2_frame_t f;
      f.code       = code;
      f.parity_err = bad_parity && (n_bits == PS2_FRAME_BITS);   // Full frames only.
      f.frame_err  = bad_start || bad_stop || (n_bits != PS2_FRAME_BITS);
      send_frame(code, bad_parity, bad_start, bad_stop, n_bits);
      if (exp_q.size() < FIFO_DEPTH) begin
         exp_q.push_back({1'b1, 5'b0, f.frame_err, f.parity_err, f.code});
         // Code not compared on short frames.
         mask_q.push_back(n_bits == PS2_FRAME_BITS ? 16'hffff : 16'hff00);
      end else begin
         model_ovf = 1'b1;   // Dropped.
      end
      wait_frame();
   endtask

   task automatic end_test(input int num, input string name);
      $display("Test %0d, %s: finished with %0d errors", num, name, errors - errors_before);
      errors_before = errors;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence.

   initial begin
      int          n_cut;
      int          assert_fails;
      logic [15:0] wr_resp;   // Read data of a write cycle, unused.
      reset    = 1'b1;
      ps2_clk  = 1'b1;
      ps2_data = 1'b1;
      wb_req   = '0;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      read_status();
      read_data();
      end_test(1, "reset values");

      for (int i = 0; i < 20; i++) begin
         send_checked(rand_byte(), 1'b0, 1'b0, 1'b0, PS2_FRAME_BITS);
         if (i % 2 == 1) begin   // Two entries queued.
            read_status();
            read_data();
            read_data();
         end
      end
      end_test(2, "random bytes in order");

      send_checked(rand_byte(), 1'b1, 1'b0, 1'b0, PS2_FRAME_BITS);
      read_data();
      send_checked(rand_byte(), 1'b0, 1'b1, 1'b0, PS2_FRAME_BITS);
      read_data();
      send_checked(rand_byte(), 1'b0, 1'b0, 1'b1, PS2_FRAME_BITS);
      read_data();
      end_test(3, "parity, start and stop errors");

      n_cut = 1 + ($unsigned($random(seed)) % 10);
      send_checked(rand_byte(), 1'b0, 1'b0, 1'b0, n_cut);
      read_status();
      read_data();
      end_test(4, "short frame");

      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         send_checked(rand_byte(), 1'b0, 1'b0, 1'b0, PS2_FRAME_BITS);
      end
      read_status();   // Full with overflow.
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         read_data();
      end
      read_status();
      bus_access(1'b1, ADDR_STATUS, 16'h0100, wr_resp);
      model_ovf = 1'b0;
      read_status();
      end_test(5, "overflow and clear");

      read_data();
      read_status();
      end_test(6, "empty read");

      assert_fails = ps2_keyboard_port_inst.properties_inst.fail_count;
      errors += assert_fails;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
logic/ps2_pkg.sv
logic/wb_pkg.sv
logic/ps2_rx.sv
logic/scan_fifo.sv
logic/ps2_wb_regs.sv
logic/ps2_keyboard_port.sv
sim/ps2_keyboard_port_properties.sv
sim/ps2_keyboard_port_tb.sv

//--- Makefile
# Verilator build and run of the PS/2 keyboard port testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ps2_keyboard_port_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# Pass only when the pass line shows up in the output.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
